// ==== Makefile ====
VERILATOR = verilator
VFLAGS    = --binary --timing --assert --timescale 1ns/1ps
TOP       = tb_lcd_controller
FILELIST  = tb.f
LOG       = sim.log
PASS_MSG  = Finished with no errors

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)
	./obj_dir/V$(TOP) > $(LOG) 2>&1 || true
	cat $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

// ==== tb.f ====
verilog/lcd_timing_pkg.sv
verilog/lcd_cmd_pkg.sv
verilog/lcd_write_if.sv
verilog/cmd_fifo.sv
verilog/delay_timer.sv
verilog/nibble_writer.sv
verilog/lcd_sequencer.sv
verilog/lcd_controller.sv
verif/lcd_bus_model.sv
verif/tb_lcd_controller.sv

// ==== verif/lcd_bus_model.sv ====
module lcd_bus_model (
  input  logic        clk,
  input  logic        rst,
  input  logic [3:0]  db,
  input  logic        lcd_e,
  input  logic        lcd_rs,
  output logic        item_valid,
  output logic [7:0]  item_data,
  output logic        item_rs,
  output logic        item_nibble,
  output logic [31:0] item_width_hi,
  output logic [31:0] item_width_lo,
  output logic [31:0] item_gap
);
  timeunit 1ns;
  timeprecision 1ps;

  logic        e_q;
  logic [3:0]  nib_q;
  logic        rs_q;
  logic        bus4;
  logic        have_hi;
  logic [3:0]  hi_nib;
  logic        hi_rs;
  logic [31:0] hi_width;
  logic [31:0] hi_gap;
  logic [31:0] width_cnt;
  logic [31:0] gap_cnt;
  logic [31:0] cur_gap;

  // pins sampled on the rising clock, strobe edges found from the samples
  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      e_q           <= 1'b0;
      nib_q         <= 4'h0;
      rs_q          <= 1'b0;
      bus4          <= 1'b0;
      have_hi       <= 1'b0;
      hi_nib        <= 4'h0;
      hi_rs         <= 1'b0;
      hi_width      <= '0;
      hi_gap        <= '0;
      width_cnt     <= '0;
      gap_cnt       <= '0;
      cur_gap       <= '0;
      item_valid    <= 1'b0;
      item_data     <= 8'h00;
      item_rs       <= 1'b0;
      item_nibble   <= 1'b0;
      item_width_hi <= '0;
      item_width_lo <= '0;
      item_gap      <= '0;
    end else begin
      e_q        <= lcd_e;
      item_valid <= 1'b0;
      if (lcd_e) begin
        nib_q     <= db;
        rs_q      <= lcd_rs;
        width_cnt <= e_q ? width_cnt + 32'd1 : 32'd1;
        if (!e_q) begin
          cur_gap <= gap_cnt;
        end
      end else begin
        gap_cnt <= e_q ? 32'd1 : gap_cnt + 32'd1;
      end
      // the panel latches on the falling strobe
      if (e_q && !lcd_e) begin
        if (!bus4) begin
          item_valid    <= 1'b1;
          item_nibble   <= 1'b1;
          item_rs       <= rs_q;
          item_data     <= {4'h0, nib_q};
          item_width_hi <= width_cnt;
          item_width_lo <= width_cnt;
          item_gap      <= cur_gap;
          // 0x2 on the upper lines selects the 4-bit bus
          if (nib_q == 4'h2) begin
            bus4 <= 1'b1;
          end
        end else if (!have_hi) begin
          have_hi  <= 1'b1;
          hi_nib   <= nib_q;
          hi_rs    <= rs_q;
          hi_width <= width_cnt;
          hi_gap   <= cur_gap;
        end else begin
          have_hi       <= 1'b0;
          item_valid    <= 1'b1;
          item_nibble   <= 1'b0;
          item_rs       <= hi_rs;
          item_data     <= {hi_nib, nib_q};
          item_width_hi <= hi_width;
          item_width_lo <= width_cnt;
          item_gap      <= hi_gap;
        end
      end
    end
  end

endmodule

// ==== verif/tb_lcd_controller.sv ====
module tb_lcd_controller
  import lcd_timing_pkg::*;
();
  timeunit 1ns;
  timeprecision 1ps;

  localparam int INIT_ITEMS    = 8;
  localparam int INIT_TIMEOUT  = 1200000;
  localparam int WRITE_TIMEOUT = 200000;
  localparam int DRAIN_TIMEOUT = 800000;

  logic        clk;
  logic        rst;
  logic        en;
  logic        cmd;
  logic [7:0]  data;
  logic [3:0]  db;
  logic        lcd_e;
  logic        lcd_rs;
  logic        busy;

  logic        item_valid;
  logic [7:0]  item_data;
  logic        item_rs;
  logic        item_nibble;
  logic [31:0] item_width_hi;
  logic [31:0] item_width_lo;
  logic [31:0] item_gap;

  // accepted user writes as {is_cmd, data}
  logic [8:0]  accepted [$];
  logic [7:0]  cmd_list [4] = '{8'h01, 8'h02, 8'h03, 8'h0C};
  int          n_seen;
  logic        prev_long;
  logic [31:0] rng;
  logic        saw_busy;

  lcd_controller u_dut (
    .clk    (clk),
    .rst    (rst),
    .en     (en),
    .cmd    (cmd),
    .data   (data),
    .db     (db),
    .lcd_e  (lcd_e),
    .lcd_rs (lcd_rs),
    .busy   (busy)
  );

  lcd_bus_model u_panel (
    .clk           (clk),
    .rst           (rst),
    .db            (db),
    .lcd_e         (lcd_e),
    .lcd_rs        (lcd_rs),
    .item_valid    (item_valid),
    .item_data     (item_data),
    .item_rs       (item_rs),
    .item_nibble   (item_nibble),
    .item_width_hi (item_width_hi),
    .item_width_lo (item_width_lo),
    .item_gap      (item_gap)
  );

  always #10 clk = ~clk;

  function automatic logic [31:0] xorshift(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  // item idx of the panel stream as {nibble_only, rs, data}
  function automatic logic [9:0] expected_stream(input int idx);
    logic [8:0] w;
    if (idx >= INIT_ITEMS) begin
      w = accepted[idx - INIT_ITEMS];
      // commands go out with rs low
      return {1'b0, !w[8], w[7:0]};
    end
    case (idx)
      0, 1, 2: return {2'b10, 8'h03};
      3:       return {2'b10, 8'h02};
      4:       return {2'b00, 8'h28};
      5:       return {2'b00, 8'h06};
      6:       return {2'b00, 8'h0D};
      default: return {2'b00, 8'h01};
    endcase
  endfunction

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("Finished with errors");
    $fatal(1, "simulation stopped");
  endtask

  task automatic compare_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
    if (expected !== actual) begin
      abort_run($sformatf("CHECK FAILED %s: expected 0x%0h, actual 0x%0h",
                          name, expected, actual));
    end
  endtask

  task automatic wait_not_busy(input int limit, input string what);
    int cycles;
    cycles = 0;
    while (busy) begin
      @(posedge clk);
      cycles++;
      if (cycles > limit) begin
        abort_run({"timeout while busy stayed high during ", what});
      end
    end
  endtask

  task automatic wait_items(input int target, input int limit);
    int cycles;
    cycles = 0;
    while (n_seen < target) begin
      @(posedge clk);
      cycles++;
      if (cycles > limit) begin
        abort_run($sformatf("timeout, panel showed %0d of %0d writes", n_seen, target));
      end
    end
  endtask

  task automatic write_byte(input logic is_cmd, input logic [7:0] b);
    wait_not_busy(WRITE_TIMEOUT, "a single write");
    en   <= 1'b1;
    cmd  <= is_cmd;
    data <= b;
    @(posedge clk);
    en   <= 1'b0;
  endtask

  // same acceptance rule the user side sees
  always @(posedge clk) begin
    if (!rst && en && !busy) begin
      accepted.push_back({cmd, data});
    end
  end

  //////////////////////////////////////////////////////////////////////
  // compare each panel item against the expected stream

  always @(posedge clk) begin
    if (rst) begin
      n_seen    <= 0;
      prev_long <= 1'b0;
    end else if (item_valid) begin
      if (n_seen >= INIT_ITEMS + accepted.size()) begin
        abort_run("panel showed a write that was never accepted");
      end else begin
        compare_value($sformatf("panel item %0d", n_seen), 32'(expected_stream(n_seen)),
                      32'({item_nibble, item_rs, item_data}));
        compare_value("first strobe width", 32'(E_HIGH_CYCLES), item_width_hi);
        compare_value("second strobe width", 32'(E_HIGH_CYCLES), item_width_lo);
        if (prev_long && item_gap < 32'(POST_WRITE_CYCLES + CLEAR_HOME_CYCLES)) begin
          abort_run("strobe came too soon after a clear or home command");
        end
        // clear is 0x01, home is 0000_001x
        prev_long <= !item_nibble && !item_rs &&
                     (item_data == 8'h01 || item_data[7:1] == 7'h01);
        n_seen    <= n_seen + 1;
      end
    end
  end

  //////////////////////////////////////////////////////////////////////
  // stimulus

  initial begin
    clk      = 1'b0;
    rst      = 1'b1;
    en       = 1'b0;
    cmd      = 1'b0;
    data     = 8'h00;
    rng      = 32'hc592;
    saw_busy = 1'b0;
    repeat (3) @(posedge clk);
    rst <= 1'b0;
    @(posedge clk);

    // pins idle after reset
    compare_value("reset lcd_e", 32'd0, 32'(lcd_e));
    compare_value("reset db", 32'd0, 32'(db));
    compare_value("reset lcd_rs", 32'd0, 32'(lcd_rs));
    compare_value("reset busy", 32'd1, 32'(busy));

    // power-on and configuration run before busy falls
    wait_not_busy(INIT_TIMEOUT, "the init sequence");
    compare_value("init item count", 32'(INIT_ITEMS), 32'(n_seen));

    // random characters
    repeat (6) begin
      rng = xorshift(rng);
      write_byte(1'b0, rng[7:0]);
    end

    // commands, each followed by a character
    foreach (cmd_list[i]) begin
      write_byte(1'b1, cmd_list[i]);
      rng = xorshift(rng);
      write_byte(1'b0, rng[7:0]);
    end

    // back-to-back burst against the FIFO
    for (int i = 0; i < 24; i++) begin
      rng  = xorshift(rng);
      en   <= 1'b1;
      cmd  <= 1'b0;
      data <= rng[7:0];
      @(posedge clk);
      if (busy) begin
        saw_busy = 1'b1;
      end
    end
    en <= 1'b0;
    @(posedge clk);
    compare_value("busy during burst", 32'd1, 32'(saw_busy));

    wait_items(INIT_ITEMS + accepted.size(), DRAIN_TIMEOUT);
    // quiet period, nothing more may show up
    repeat (5000) @(posedge clk);
    // FIFO drained, so busy must be low again
    compare_value("busy after drain", 32'd0, 32'(busy));

    $display("Finished with no errors");
    $finish;
  end

endmodule

// ==== verilog/cmd_fifo.sv ====
module cmd_fifo
  import lcd_cmd_pkg::*;
#(
  parameter int DEPTH = FIFO_DEPTH
) (
  input  logic        clk,
  input  logic        rst,
  input  logic        push,
  input  fifo_entry_t push_entry,
  input  logic        pop,
  output fifo_entry_t pop_entry,
  output logic        empty,
  output logic        full
);

  localparam int PTR_W = $clog2(DEPTH);
  localparam int CNT_W = $clog2(DEPTH + 1);

  fifo_entry_t      mem [DEPTH];
  logic [PTR_W-1:0] head;
  logic [PTR_W-1:0] tail;
  logic [CNT_W-1:0] count;
  logic             do_push;
  logic             do_pop;

  function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] p);
    return (p == PTR_W'(DEPTH - 1)) ? '0 : p + 1'b1;
  endfunction

  assign empty   = (count == '0);
  assign full    = (count == CNT_W'(DEPTH));
  assign do_push = push && !full;
  assign do_pop  = pop && !empty;

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      head  <= '0;
      tail  <= '0;
      count <= '0;
    end else begin
      if (do_push) begin
        tail <= ptr_inc(tail);
      end
      if (do_pop) begin
        head <= ptr_inc(head);
      end
      case ({do_push, do_pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  // storage, read data lands the cycle after pop
  always_ff @(posedge clk) begin
    if (do_push) begin
      mem[tail] <= push_entry;
    end
    if (do_pop) begin
      pop_entry <= mem[head];
    end
  end

  a_no_pop_empty: assert property (@(posedge clk) disable iff (rst) pop |-> !empty);

endmodule

// ==== verilog/delay_timer.sv ====
module delay_timer
  import lcd_timing_pkg::*;
(
  input  logic       clk,
  input  logic       rst,
  input  logic       req,
  input  delay_sel_e sel,
  output logic       ack
);

  logic [DELAY_W-1:0] cnt;
  logic [DELAY_W-1:0] load_cnt;
  logic               active;

  always_comb begin
    case (sel)
      DLY_POWER_ON: load_cnt = DELAY_W'(POWER_ON_CYCLES - 1);
      DLY_WAKE1:    load_cnt = DELAY_W'(WAKE1_CYCLES - 1);
      DLY_WAKE2:    load_cnt = DELAY_W'(WAKE2_CYCLES - 1);
      default:      load_cnt = DELAY_W'(WAKE3_CYCLES - 1);
    endcase
  end

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      cnt    <= '0;
      active <= 1'b0;
      ack    <= 1'b0;
    end else if (active) begin
      if (cnt == '0) begin
        active <= 1'b0;
        ack    <= 1'b1;
      end else begin
        cnt <= cnt - 1'b1;
      end
    end else if (ack) begin
      // hold until the requester lets go
      ack <= req;
    end else if (req) begin
      cnt    <= load_cnt;
      active <= 1'b1;
    end
  end

  a_sel_stable: assert property (@(posedge clk) disable iff (rst)
    $past(req) && req |-> sel == $past(sel));

endmodule

// ==== verilog/lcd_cmd_pkg.sv ====
package lcd_cmd_pkg;
  import lcd_timing_pkg::*;

  // configuration commands
  localparam logic [7:0] CMD_FUNCTION_SET = 8'h28;
  localparam logic [7:0] CMD_ENTRY_MODE   = 8'h06;
  localparam logic [7:0] CMD_DISPLAY_CTRL = 8'h0D;
  localparam logic [7:0] CMD_CLEAR        = 8'h01;

  // home is 0000_001x, bit 0 ignored by the panel
  localparam logic [6:0] HOME_OPCODE = 7'h01;

  // wake-up nibbles, sent on db alone
  localparam logic [3:0] WAKE_NIBBLE = 4'h3;
  localparam logic [3:0] BUS4_NIBBLE = 4'h2;

  localparam int SCRIPT_LEN = 12;
  localparam int FIFO_DEPTH = 16;

  // sequencer states
  localparam logic [2:0] SQ_RUN   = 3'd0;
  localparam logic [2:0] SQ_STEP  = 3'd1;
  localparam logic [2:0] SQ_IDLE  = 3'd2;
  localparam logic [2:0] SQ_FETCH = 3'd3;
  localparam logic [2:0] SQ_WRITE = 3'd4;

  typedef struct packed {
    logic       is_cmd;
    logic [7:0] data;
  } fifo_entry_t;

  // script step, tag bit on top in both views
  typedef struct packed {
    logic       is_wait;
    logic       nibble_only;
    logic       rs;
    logic [7:0] data;
  } script_write_t;

  typedef struct packed {
    logic       is_wait;
    logic [7:0] pad;
    delay_sel_e sel;
  } script_wait_t;

  typedef union packed {
    script_write_t wr;
    script_wait_t  dly;
  } script_step_u;

endpackage

// ==== verilog/lcd_controller.sv ====
module lcd_controller
  import lcd_timing_pkg::*;
  import lcd_cmd_pkg::*;
(
  input  logic       clk,
  input  logic       rst,
  input  logic       en,
  input  logic       cmd,
  input  logic [7:0] data,
  output logic [3:0] db,
  output logic       lcd_e,
  output logic       lcd_rs,
  output logic       busy
);

  lcd_write_if wr_bus ();

  logic        fifo_push;
  logic        fifo_pop;
  logic        fifo_empty;
  logic        fifo_full;
  fifo_entry_t fifo_entry;
  fifo_entry_t fifo_head;
  logic        dly_req;
  logic        dly_ack;
  delay_sel_e  dly_sel;

  lcd_sequencer u_seq (
    .clk        (clk),
    .rst        (rst),
    .en         (en),
    .cmd        (cmd),
    .data       (data),
    .busy       (busy),
    .fifo_push  (fifo_push),
    .fifo_entry (fifo_entry),
    .fifo_pop   (fifo_pop),
    .fifo_head  (fifo_head),
    .fifo_empty (fifo_empty),
    .fifo_full  (fifo_full),
    .dly_req    (dly_req),
    .dly_sel    (dly_sel),
    .dly_ack    (dly_ack),
    .wr         (wr_bus.master)
  );

  // pending user writes
  cmd_fifo #(.DEPTH(FIFO_DEPTH)) u_fifo (
    .clk        (clk),
    .rst        (rst),
    .push       (fifo_push),
    .push_entry (fifo_entry),
    .pop        (fifo_pop),
    .pop_entry  (fifo_head),
    .empty      (fifo_empty),
    .full       (fifo_full)
  );

  delay_timer u_timer (
    .clk (clk),
    .rst (rst),
    .req (dly_req),
    .sel (dly_sel),
    .ack (dly_ack)
  );

  nibble_writer u_writer (
    .clk    (clk),
    .rst    (rst),
    .wr     (wr_bus.slave),
    .db     (db),
    .lcd_e  (lcd_e),
    .lcd_rs (lcd_rs)
  );

endmodule

// ==== verilog/lcd_sequencer.sv ====
module lcd_sequencer
  import lcd_timing_pkg::*;
  import lcd_cmd_pkg::*;
(
  input  logic         clk,
  input  logic         rst,
  input  logic         en,
  input  logic         cmd,
  input  logic [7:0]   data,
  output logic         busy,
  output logic         fifo_push,
  output fifo_entry_t  fifo_entry,
  output logic         fifo_pop,
  input  fifo_entry_t  fifo_head,
  input  logic         fifo_empty,
  input  logic         fifo_full,
  output logic         dly_req,
  output delay_sel_e   dly_sel,
  input  logic         dly_ack,
  lcd_write_if.master  wr
);

  logic [$clog2(SCRIPT_LEN)-1:0] step_idx;
  script_step_u                  step;
  logic [2:0]                    state;
  logic                          issue;
  logic                          last_step;

  function automatic script_step_u wait_step(input delay_sel_e sel);
    script_step_u s;
    s             = '0;
    s.dly.is_wait = 1'b1;
    s.dly.sel     = sel;
    return s;
  endfunction

  function automatic script_step_u write_step(input logic nib, input logic [7:0] b);
    script_step_u s;
    s                = '0;
    s.wr.nibble_only = nib;
    s.wr.data        = b;
    return s;
  endfunction

  //////////////////////////////////////////////////////////////////////
  // power-on and configuration script

  always_comb begin
    case (step_idx)
      4'd0:    step = wait_step(DLY_POWER_ON);
      4'd1:    step = write_step(1'b1, {WAKE_NIBBLE, 4'h0});
      4'd2:    step = wait_step(DLY_WAKE1);
      4'd3:    step = write_step(1'b1, {WAKE_NIBBLE, 4'h0});
      4'd4:    step = wait_step(DLY_WAKE2);
      4'd5:    step = write_step(1'b1, {WAKE_NIBBLE, 4'h0});
      4'd6:    step = wait_step(DLY_WAKE3);
      // switch the panel to the 4-bit bus
      4'd7:    step = write_step(1'b1, {BUS4_NIBBLE, 4'h0});
      4'd8:    step = write_step(1'b0, CMD_FUNCTION_SET);
      4'd9:    step = write_step(1'b0, CMD_ENTRY_MODE);
      4'd10:   step = write_step(1'b0, CMD_DISPLAY_CTRL);
      default: step = write_step(1'b0, CMD_CLEAR);
    endcase
  end

  assign last_step = (int'(step_idx) == SCRIPT_LEN - 1);
  assign issue     = (state == SQ_RUN) && !dly_ack && !wr.ack;

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      state    <= SQ_RUN;
      step_idx <= '0;
      dly_req  <= 1'b0;
      wr.req   <= 1'b0;
    end else begin
      case (state)
        SQ_RUN: begin
          if (issue) begin
            if (step.wr.is_wait) begin
              dly_req <= 1'b1;
            end else begin
              wr.req <= 1'b1;
            end
            state <= SQ_STEP;
          end
        end
        SQ_STEP: begin
          if ((dly_req && dly_ack) || (wr.req && wr.ack)) begin
            dly_req <= 1'b0;
            wr.req  <= 1'b0;
            if (last_step) begin
              state <= SQ_IDLE;
            end else begin
              step_idx <= step_idx + 1'b1;
              state    <= SQ_RUN;
            end
          end
        end
        // normal mode, one FIFO entry per write
        SQ_IDLE: begin
          if (fifo_pop) begin
            state <= SQ_FETCH;
          end
        end
        SQ_FETCH: begin
          wr.req <= 1'b1;
          state  <= SQ_WRITE;
        end
        SQ_WRITE: begin
          if (wr.ack) begin
            wr.req <= 1'b0;
            state  <= SQ_IDLE;
          end
        end
        default: state <= SQ_IDLE;
      endcase
    end
  end

  // request fields, held until the matching ack drops
  always_ff @(posedge clk) begin
    if (issue) begin
      dly_sel        <= step.dly.sel;
      wr.rs          <= step.wr.rs;
      wr.nibble_only <= step.wr.nibble_only;
      wr.data        <= step.wr.data;
    end else if (state == SQ_FETCH) begin
      wr.rs          <= !fifo_head.is_cmd;
      wr.nibble_only <= 1'b0;
      wr.data        <= fifo_head.data;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // user side

  assign fifo_pop          = (state == SQ_IDLE) && !fifo_empty && !wr.ack;
  assign busy              = (state == SQ_RUN) || (state == SQ_STEP) || fifo_full;
  assign fifo_push         = en && !busy;
  assign fifo_entry.is_cmd = cmd;
  assign fifo_entry.data   = data;

  // write fields frozen from req rising until ack falls
  a_wr_fields_stable: assert property (@(posedge clk) disable iff (rst)
    (wr.req || wr.ack) && $past(wr.req || wr.ack) |->
      $stable({wr.rs, wr.nibble_only, wr.data}));

endmodule

// ==== verilog/lcd_timing_pkg.sv ====
package lcd_timing_pkg;

  // counter width, large enough for the 15 ms power-on wait at 50 MHz
  localparam int DELAY_W = 20;

  // strobe and per-write timing
  localparam int E_SETUP_CYCLES    = 2;
  localparam int E_HIGH_CYCLES     = 12;
  localparam int NIBBLE_GAP_CYCLES = 50;
  localparam int POST_WRITE_CYCLES = 2000;
  localparam int CLEAR_HOME_CYCLES = 82000;

  // power-on waits
  localparam int POWER_ON_CYCLES = 750000;
  localparam int WAKE1_CYCLES    = 205000;
  localparam int WAKE2_CYCLES    = 5000;
  localparam int WAKE3_CYCLES    = 2000;

  typedef enum logic [1:0] {
    DLY_POWER_ON,
    DLY_WAKE1,
    DLY_WAKE2,
    DLY_WAKE3
  } delay_sel_e;

  // nibble writer phases
  localparam logic [3:0] PH_IDLE      = 4'd0;
  localparam logic [3:0] PH_HI_SETUP  = 4'd1;
  localparam logic [3:0] PH_HI_STROBE = 4'd2;
  localparam logic [3:0] PH_GAP       = 4'd3;
  localparam logic [3:0] PH_LO_SETUP  = 4'd4;
  localparam logic [3:0] PH_LO_STROBE = 4'd5;
  localparam logic [3:0] PH_POST      = 4'd6;
  localparam logic [3:0] PH_LONG      = 4'd7;
  localparam logic [3:0] PH_ACK       = 4'd8;

endpackage

// ==== verilog/lcd_write_if.sv ====
interface lcd_write_if;

  // four-phase request, fields held until ack falls
  logic       req;
  logic       ack;
  logic       rs;
  logic       nibble_only;
  logic [7:0] data;

  modport master (
    output req,
    output rs,
    output nibble_only,
    output data,
    input  ack
  );

  modport slave (
    input  req,
    input  rs,
    input  nibble_only,
    input  data,
    output ack
  );

endinterface

// ==== verilog/nibble_writer.sv ====
module nibble_writer
  import lcd_timing_pkg::*;
  import lcd_cmd_pkg::*;
(
  input  logic       clk,
  input  logic       rst,
  lcd_write_if.slave wr,
  output logic [3:0] db,
  output logic       lcd_e,
  output logic       lcd_rs
);

  logic [3:0]         phase;
  logic [3:0]         next_phase;
  logic [DELAY_W-1:0] cnt;
  logic [DELAY_W-1:0] next_cnt;
  logic               clear_home;

  // clear and home need the long pause, commands only
  assign clear_home = !wr.rs && !wr.nibble_only &&
                      (wr.data == CMD_CLEAR || wr.data[7:1] == HOME_OPCODE);

  //////////////////////////////////////////////////////////////////////
  // phase sequencing

  always_comb begin
    next_phase = phase;
    next_cnt   = '0;
    case (phase)
      PH_IDLE: begin
        if (wr.req) begin
          next_phase = PH_HI_SETUP;
          next_cnt   = DELAY_W'(E_SETUP_CYCLES - 1);
        end
      end
      PH_HI_SETUP: begin
        next_phase = PH_HI_STROBE;
        next_cnt   = DELAY_W'(E_HIGH_CYCLES - 1);
      end
      PH_HI_STROBE: begin
        if (wr.nibble_only) begin
          next_phase = PH_POST;
          next_cnt   = DELAY_W'(POST_WRITE_CYCLES - 1);
        end else begin
          next_phase = PH_GAP;
          next_cnt   = DELAY_W'(NIBBLE_GAP_CYCLES - 1);
        end
      end
      PH_GAP: begin
        next_phase = PH_LO_SETUP;
        next_cnt   = DELAY_W'(E_SETUP_CYCLES - 1);
      end
      PH_LO_SETUP: begin
        next_phase = PH_LO_STROBE;
        next_cnt   = DELAY_W'(E_HIGH_CYCLES - 1);
      end
      PH_LO_STROBE: begin
        next_phase = PH_POST;
        next_cnt   = DELAY_W'(POST_WRITE_CYCLES - 1);
      end
      PH_POST: begin
        if (clear_home) begin
          next_phase = PH_LONG;
          next_cnt   = DELAY_W'(CLEAR_HOME_CYCLES - 1);
        end else begin
          next_phase = PH_ACK;
        end
      end
      PH_LONG: next_phase = PH_ACK;
      PH_ACK:  next_phase = wr.req ? PH_ACK : PH_IDLE;
      default: next_phase = PH_IDLE;
    endcase
  end

  // one counter, phase moves on when it runs out
  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      phase <= PH_IDLE;
      cnt   <= '0;
    end else if (cnt == '0) begin
      phase <= next_phase;
      cnt   <= next_cnt;
    end else begin
      cnt <= cnt - 1'b1;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // panel pins

  always_comb begin
    case (phase)
      PH_HI_SETUP, PH_HI_STROBE: db = wr.data[7:4];
      PH_LO_SETUP, PH_LO_STROBE: db = wr.data[3:0];
      default:                   db = 4'h0;
    endcase
  end

  assign lcd_e  = (phase == PH_HI_STROBE) || (phase == PH_LO_STROBE);
  assign lcd_rs = (phase != PH_IDLE) && wr.rs;
  assign wr.ack = (phase == PH_ACK);

  // nibble and rs already settled when the strobe rises, and held through it
  a_strobe_stable: assert property (@(posedge clk) disable iff (rst)
    lcd_e |-> wr.req && $stable(db) && $stable(lcd_rs));

endmodule
